// File: pcie_dl_pkg.sv
//////////////////////////////////////////////////
// link-layer constants for the receive path
// LCRC is non-reflected CRC-32, MSB first, one dword per beat
// buffer depth must exceed MAX_TLP_DW plus one spare slot
//////////////////////////////////////////////////
package pcie_dl_pkg;

  localparam int SEQ_W = 12;

  typedef logic [SEQ_W-1:0] seq_num_t;
  typedef logic [31:0] dword_t;
  typedef logic [31:0] lcrc_t;

  // CRC-32 generator and start value
  localparam lcrc_t LCRC_POLY = 32'h04C1_1DB7;
  localparam lcrc_t LCRC_SEED = 32'hFFFF_FFFF;

  // 4 header dwords plus 16 payload dwords
  localparam int MAX_TLP_DW = 20;

  localparam int BUF_DEPTH = 64;

  typedef logic [5:0] buf_ptr_t;

  // ingress framing states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEQ,
    ST_BODY,
    ST_WAIT_VERDICT
  } ingress_st_e;

endpackage

// File: pcie_tlp_pkg.sv
//////////////////////////////////////////////////
// TLP header fields used for credit accounting
// only DW0 is decoded: fmt data bit, type, length
//////////////////////////////////////////////////
package pcie_tlp_pkg;

  typedef logic [9:0] tlp_len_t;
  typedef logic [7:0] hdr_credit_t;
  typedef logic [11:0] data_credit_t;

  // fmt[1] set means the TLP carries a payload
  localparam int FMT_DATA_BIT = 30;

  // type field of DW0
  localparam int TYPE_MSB = 28;
  localparam int TYPE_LSB = 24;

  // length field of DW0, in dwords, 0 encodes 1024
  localparam int LEN_MSB = 9;
  localparam int LEN_LSB = 0;

  // memory request, read or write depending on fmt
  localparam logic [4:0] TYPE_MEM = 5'h00;

  // completion, with or without data
  localparam logic [4:0] TYPE_CPL = 5'h0A;

endpackage

// File: dl_rx_ingress.sv
//////////////////////////////////////////////////
// input skid buffer and frame tagging
// every beat is a full dword, tkeep is not supported
// a new frame starts only with link up, space and no pending report
//////////////////////////////////////////////////
`timescale 1ns/1ns

module dl_rx_ingress (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  pcie_dl_pkg::dword_t   s_axis_tdata_i,
  input  logic                  s_axis_tvalid_i,
  input  logic                  s_axis_tlast_i,
  output logic                  s_axis_tready_o,
  input  logic                  link_up_i,
  input  logic                  space_ok_i,
  input  logic                  report_busy_i,
  output logic                  beat_valid_o,
  output pcie_dl_pkg::dword_t   beat_data_o,
  output logic                  beat_is_seq_o,
  output logic                  beat_is_hdr0_o,
  output logic                  beat_is_lcrc_o
);

  // skid entries hold {tlast, tdata}
  logic [32:0] ent0_q;
  logic [32:0] ent1_q;
  logic [1:0]  cnt_q;
  logic [1:0]  cnt_d;
  logic        tready_q;
  logic        push;
  logic        pop;
  logic        can_take;
  logic        head_last;
  pcie_dl_pkg::ingress_st_e st_q;
  pcie_dl_pkg::ingress_st_e st_d;

  assign push      = s_axis_tvalid_i && tready_q;
  assign head_last = ent0_q[32];
  assign pop       = can_take && (cnt_q != 2'd0);

  always_comb begin
    case (st_q)
      pcie_dl_pkg::ST_IDLE:         can_take = link_up_i && space_ok_i && !report_busy_i;
      pcie_dl_pkg::ST_WAIT_VERDICT: can_take = 1'b0;
      default:                      can_take = 1'b1;
    endcase
  end

  always_comb begin
    st_d = st_q;
    case (st_q)
      pcie_dl_pkg::ST_IDLE: begin
        if (pop) st_d = pcie_dl_pkg::ST_SEQ;
      end
      pcie_dl_pkg::ST_SEQ: begin
        if (pop) st_d = head_last ? pcie_dl_pkg::ST_WAIT_VERDICT : pcie_dl_pkg::ST_BODY;
      end
      pcie_dl_pkg::ST_BODY: begin
        if (pop && head_last) st_d = pcie_dl_pkg::ST_WAIT_VERDICT;
      end
      default: st_d = pcie_dl_pkg::ST_IDLE;
    endcase
  end

  always_comb begin
    cnt_d = cnt_q;
    if (push && !pop) cnt_d = cnt_q + 2'd1;
    else if (pop && !push) cnt_d = cnt_q - 2'd1;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q    <= 2'd0;
      st_q     <= pcie_dl_pkg::ST_IDLE;
      tready_q <= 1'b0;
    end else begin
      cnt_q    <= cnt_d;
      st_q     <= st_d;
      // a frame in flight keeps ready up even if the link drops
      tready_q <= (cnt_d != 2'd2) && (link_up_i || st_d != pcie_dl_pkg::ST_IDLE);
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop && cnt_q == 2'd2) ent0_q <= ent1_q;
    else if (push && (pop || cnt_q == 2'd0)) ent0_q <= {s_axis_tlast_i, s_axis_tdata_i};
    if (push && (cnt_q == 2'd2 || (cnt_q == 2'd1 && !pop))) begin
      ent1_q <= {s_axis_tlast_i, s_axis_tdata_i};
    end
  end

  assign s_axis_tready_o = tready_q;
  assign beat_valid_o    = pop;
  assign beat_data_o     = ent0_q[31:0];
  assign beat_is_seq_o   = pop && (st_q == pcie_dl_pkg::ST_IDLE);
  assign beat_is_hdr0_o  = pop && (st_q == pcie_dl_pkg::ST_SEQ) && !head_last;
  assign beat_is_lcrc_o  = pop && (st_q != pcie_dl_pkg::ST_IDLE) && head_last;

endmodule

// File: dl_rx_frame_check.sv
//////////////////////////////////////////////////
// LCRC and sequence check with ack/nak report
// sequence word carries the number in bits 11:0
// report holds until ack_ready_i, no new frame meanwhile
//////////////////////////////////////////////////
`timescale 1ns/1ns

module dl_rx_frame_check (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  beat_valid_i,
  input  pcie_dl_pkg::dword_t   beat_data_i,
  input  logic                  beat_is_seq_i,
  input  logic                  beat_is_lcrc_i,
  input  logic                  ack_ready_i,
  output logic                  verdict_valid_o,
  output logic                  verdict_good_o,
  output logic                  report_busy_o,
  output logic                  ack_valid_o,
  output logic                  ack_nak_o,
  output pcie_dl_pkg::seq_num_t ack_seq_o
);

  pcie_dl_pkg::lcrc_t    crc_q;
  pcie_dl_pkg::lcrc_t    crc_d;
  pcie_dl_pkg::seq_num_t seq_rx_q;
  pcie_dl_pkg::seq_num_t exp_seq_q;
  logic                  verdict_valid_q;
  logic                  verdict_good_q;
  logic                  ack_valid_q;
  logic                  ack_nak_q;
  logic                  lcrc_beat;
  logic                  frame_good;

  // one dword, MSB first, no reflection
  function automatic pcie_dl_pkg::lcrc_t crc_step(pcie_dl_pkg::lcrc_t crc,
                                                  pcie_dl_pkg::dword_t data);
    pcie_dl_pkg::lcrc_t c;
    logic               fb;
    c = crc;
    for (int i = 31; i >= 0; i--) begin
      fb = c[31] ^ data[i];
      c  = {c[30:0], 1'b0};
      if (fb) c = c ^ pcie_dl_pkg::LCRC_POLY;
    end
    return c;
  endfunction

  assign crc_d      = crc_step(beat_is_seq_i ? pcie_dl_pkg::LCRC_SEED : crc_q, beat_data_i);
  assign lcrc_beat  = beat_valid_i && beat_is_lcrc_i;
  // transmitter sends the complemented remainder
  assign frame_good = ((~crc_q) == beat_data_i) && (seq_rx_q == exp_seq_q);

  always_ff @(posedge clk_i) begin
    if (beat_valid_i && !beat_is_lcrc_i) crc_q <= crc_d;
    if (beat_valid_i && beat_is_seq_i) seq_rx_q <= beat_data_i[pcie_dl_pkg::SEQ_W-1:0];
    if (lcrc_beat) verdict_good_q <= frame_good;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      verdict_valid_q <= 1'b0;
      ack_valid_q     <= 1'b0;
      ack_nak_q       <= 1'b0;
      exp_seq_q       <= '0;
    end else begin
      verdict_valid_q <= lcrc_beat;
      if (ack_valid_q && ack_ready_i) ack_valid_q <= 1'b0;
      if (lcrc_beat) begin
        ack_valid_q <= 1'b1;
        ack_nak_q   <= !frame_good;
        if (frame_good) exp_seq_q <= exp_seq_q + 1'b1;
      end
    end
  end

  assign verdict_valid_o = verdict_valid_q;
  assign verdict_good_o  = verdict_good_q;
  assign report_busy_o   = ack_valid_q;
  assign ack_valid_o     = ack_valid_q;
  assign ack_nak_o       = ack_nak_q;
  // last good sequence, 4095 before the first good frame
  assign ack_seq_o       = exp_seq_q - pcie_dl_pkg::seq_num_t'(1);

endmodule

// File: dl_rx_credit_track.sv
//////////////////////////////////////////////////
// consumed flow-control credit counters
// counters start at zero and wrap, no credit limit check
//////////////////////////////////////////////////
`timescale 1ns/1ns

module dl_rx_credit_track (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        beat_valid_i,
  input  pcie_dl_pkg::dword_t         beat_data_i,
  input  logic                        beat_is_hdr0_i,
  input  logic                        verdict_valid_i,
  input  logic                        verdict_good_i,
  output pcie_tlp_pkg::hdr_credit_t   ph_credits_o,
  output pcie_tlp_pkg::hdr_credit_t   nph_credits_o,
  output pcie_tlp_pkg::data_credit_t  pd_credits_o,
  output pcie_tlp_pkg::data_credit_t  npd_credits_o
);

  pcie_tlp_pkg::hdr_credit_t  ph_q;
  pcie_tlp_pkg::hdr_credit_t  nph_q;
  pcie_tlp_pkg::data_credit_t pd_q;
  pcie_tlp_pkg::data_credit_t npd_q;
  pcie_tlp_pkg::data_credit_t dcred_q;
  pcie_tlp_pkg::data_credit_t len_dw;
  pcie_tlp_pkg::tlp_len_t     len;
  logic [4:0]                 tlp_type;
  logic                       has_data;
  logic                       is_post_q;
  logic                       is_cpl_q;
  logic                       has_data_q;

  assign tlp_type = beat_data_i[pcie_tlp_pkg::TYPE_MSB:pcie_tlp_pkg::TYPE_LSB];
  assign has_data = beat_data_i[pcie_tlp_pkg::FMT_DATA_BIT];
  assign len      = beat_data_i[pcie_tlp_pkg::LEN_MSB:pcie_tlp_pkg::LEN_LSB];
  // zero length field stands for 1024 dwords
  assign len_dw   = (len == '0) ? 12'd1024 : {2'b00, len};

  // class of the frame, taken from DW0
  always_ff @(posedge clk_i) begin
    if (beat_valid_i && beat_is_hdr0_i) begin
      is_post_q  <= (tlp_type == pcie_tlp_pkg::TYPE_MEM) && has_data;
      is_cpl_q   <= (tlp_type == pcie_tlp_pkg::TYPE_CPL);
      has_data_q <= has_data;
      dcred_q    <= (len_dw + 12'd3) >> 2;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ph_q  <= '0;
      nph_q <= '0;
      pd_q  <= '0;
      npd_q <= '0;
    end else if (verdict_valid_i && verdict_good_i && !is_cpl_q) begin
      if (is_post_q) begin
        ph_q <= ph_q + 1'b1;
        pd_q <= pd_q + dcred_q;
      end else begin
        nph_q <= nph_q + 1'b1;
        if (has_data_q) npd_q <= npd_q + dcred_q;
      end
    end
  end

  assign ph_credits_o  = ph_q;
  assign nph_credits_o = nph_q;
  assign pd_credits_o  = pd_q;
  assign npd_credits_o = npd_q;

endmodule

// File: dl_rx_frame_buffer.sv
//////////////////////////////////////////////////
// frame store with commit or rewind on the verdict
// one slot stays empty so full and empty differ
// space_ok means room for a whole maximum TLP
//////////////////////////////////////////////////
`timescale 1ns/1ns

module dl_rx_frame_buffer (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  beat_valid_i,
  input  pcie_dl_pkg::dword_t   beat_data_i,
  input  logic                  beat_is_seq_i,
  input  logic                  beat_is_lcrc_i,
  input  logic                  verdict_valid_i,
  input  logic                  verdict_good_i,
  output logic                  space_ok_o,
  output pcie_dl_pkg::dword_t   m_axis_tdata_o,
  output logic                  m_axis_tvalid_o,
  output logic                  m_axis_tlast_o,
  input  logic                  m_axis_tready_i
);

  pcie_dl_pkg::dword_t             mem_q [pcie_dl_pkg::BUF_DEPTH];
  logic [pcie_dl_pkg::BUF_DEPTH-1:0] last_q;
  pcie_dl_pkg::buf_ptr_t           wr_ptr_q;
  pcie_dl_pkg::buf_ptr_t           cm_ptr_q;
  pcie_dl_pkg::buf_ptr_t           rd_ptr_q;
  pcie_dl_pkg::buf_ptr_t           used;
  logic                            wr_en;
  logic                            rd_en;
  logic                            commit;

  // only TLP dwords are stored
  assign wr_en  = beat_valid_i && !beat_is_seq_i && !beat_is_lcrc_i;
  assign rd_en  = m_axis_tvalid_o && m_axis_tready_i;
  assign commit = verdict_valid_i && verdict_good_i && (wr_ptr_q != cm_ptr_q);
  assign used   = wr_ptr_q - rd_ptr_q;

  assign space_ok_o =
    int'(used) <= pcie_dl_pkg::BUF_DEPTH - 1 - pcie_dl_pkg::MAX_TLP_DW;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q]  <= beat_data_i;
      last_q[wr_ptr_q] <= 1'b0;
    end
    // mark the final dword of the accepted frame
    if (commit) last_q[pcie_dl_pkg::buf_ptr_t'(wr_ptr_q - 1'b1)] <= 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      cm_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (verdict_valid_i) begin
        if (verdict_good_i) cm_ptr_q <= wr_ptr_q;
        else wr_ptr_q <= cm_ptr_q;
      end
      if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // reads stop at the commit pointer
  assign m_axis_tvalid_o = (rd_ptr_q != cm_ptr_q);
  assign m_axis_tdata_o  = mem_q[rd_ptr_q];
  assign m_axis_tlast_o  = last_q[rd_ptr_q];

endmodule

// File: dl_rx_top.sv
//////////////////////////////////////////////////
// receive data link layer: ingress, check, credits, buffer
//////////////////////////////////////////////////
`timescale 1ns/1ns

module dl_rx_top (
  input  logic clk_i, input logic rst_i, input logic link_up_i,
  input  pcie_dl_pkg::dword_t s_axis_tdata_i, input logic s_axis_tvalid_i,
  input  logic s_axis_tlast_i, output logic s_axis_tready_o,
  output pcie_dl_pkg::dword_t m_axis_tdata_o, output logic m_axis_tvalid_o,
  output logic m_axis_tlast_o, input logic m_axis_tready_i,
  output logic ack_valid_o, output logic ack_nak_o,
  output pcie_dl_pkg::seq_num_t ack_seq_o, input logic ack_ready_i,
  output pcie_tlp_pkg::hdr_credit_t ph_credits_o, nph_credits_o,
  output pcie_tlp_pkg::data_credit_t pd_credits_o, npd_credits_o
);

  pcie_dl_pkg::dword_t beat_data;
  logic beat_valid, beat_is_seq, beat_is_hdr0, beat_is_lcrc;
  logic verdict_valid, verdict_good, report_busy, space_ok;

  dl_rx_ingress u_ingress (.clk_i, .rst_i, .s_axis_tdata_i, .s_axis_tvalid_i,
    .s_axis_tlast_i, .s_axis_tready_o, .link_up_i, .space_ok_i(space_ok),
    .report_busy_i(report_busy), .beat_valid_o(beat_valid), .beat_data_o(beat_data),
    .beat_is_seq_o(beat_is_seq), .beat_is_hdr0_o(beat_is_hdr0),
    .beat_is_lcrc_o(beat_is_lcrc));

  dl_rx_frame_check u_frame_check (.clk_i, .rst_i, .beat_valid_i(beat_valid),
    .beat_data_i(beat_data), .beat_is_seq_i(beat_is_seq), .beat_is_lcrc_i(beat_is_lcrc),
    .ack_ready_i, .verdict_valid_o(verdict_valid), .verdict_good_o(verdict_good),
    .report_busy_o(report_busy), .ack_valid_o, .ack_nak_o, .ack_seq_o);

  dl_rx_credit_track u_credit_track (.clk_i, .rst_i, .beat_valid_i(beat_valid),
    .beat_data_i(beat_data), .beat_is_hdr0_i(beat_is_hdr0),
    .verdict_valid_i(verdict_valid), .verdict_good_i(verdict_good),
    .ph_credits_o, .nph_credits_o, .pd_credits_o, .npd_credits_o);

  dl_rx_frame_buffer u_frame_buffer (.clk_i, .rst_i, .beat_valid_i(beat_valid),
    .beat_data_i(beat_data), .beat_is_seq_i(beat_is_seq), .beat_is_lcrc_i(beat_is_lcrc),
    .verdict_valid_i(verdict_valid), .verdict_good_i(verdict_good),
    .space_ok_o(space_ok), .m_axis_tdata_o, .m_axis_tvalid_o, .m_axis_tlast_o,
    .m_axis_tready_i);

endmodule

// File: dl_rx_assert.sv
//////////////////////////////////////////////////
// handshake and reset properties, bound into dl_rx_top
// err_cnt counts failed assertions
//////////////////////////////////////////////////
`timescale 1ns/1ns

module dl_rx_assert (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  s_axis_tready_o,
  input pcie_dl_pkg::dword_t   m_axis_tdata_o,
  input logic                  m_axis_tvalid_o,
  input logic                  m_axis_tready_i,
  input logic                  ack_valid_o,
  input logic                  ack_nak_o,
  input pcie_dl_pkg::seq_num_t ack_seq_o,
  input logic                  ack_ready_i
);

  int err_cnt = 0;

  // stalled output beat holds
  a_out_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    m_axis_tvalid_o && !m_axis_tready_i |=> m_axis_tvalid_o && $stable(m_axis_tdata_o))
    else begin
      err_cnt++;
      $error("output beat changed while the sink stalled");
    end

  // pending ack report holds
  a_ack_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_valid_o && !ack_ready_i |=> ack_valid_o && $stable(ack_nak_o) && $stable(ack_seq_o))
    else begin
      err_cnt++;
      $error("ack report changed before it was accepted");
    end

  a_rst_quiet: assert property (@(posedge clk_i)
    rst_i |=> !s_axis_tready_o && !m_axis_tvalid_o && !ack_valid_o)
    else begin
      err_cnt++;
      $error("handshake output high during reset");
    end

endmodule

bind dl_rx_top dl_rx_assert u_dl_rx_assert (.*);

// File: tb_dl_rx.sv
//////////////////////////////////////////////////
// directed testbench for the receive link layer
// frames are full dwords, LCRC and credits come from a local model
// inputs change 2 ns after the rising edge, outputs are sampled at the falling edge
//////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_dl_rx;

  logic                       clk_i = 1'b0;
  logic                       rst_i;
  logic                       link_up_i;
  pcie_dl_pkg::dword_t        s_axis_tdata_i;
  logic                       s_axis_tvalid_i;
  logic                       s_axis_tlast_i;
  logic                       s_axis_tready_o;
  pcie_dl_pkg::dword_t        m_axis_tdata_o;
  logic                       m_axis_tvalid_o;
  logic                       m_axis_tlast_o;
  logic                       m_axis_tready_i;
  logic                       ack_valid_o;
  logic                       ack_nak_o;
  pcie_dl_pkg::seq_num_t      ack_seq_o;
  logic                       ack_ready_i;
  pcie_tlp_pkg::hdr_credit_t  ph_credits_o;
  pcie_tlp_pkg::hdr_credit_t  nph_credits_o;
  pcie_tlp_pkg::data_credit_t pd_credits_o;
  pcie_tlp_pkg::data_credit_t npd_credits_o;

  int unsigned lcg_state = 58;
  int errors = 0;
  int checks = 0;
  pcie_dl_pkg::dword_t   tlp_q[$];
  pcie_dl_pkg::dword_t   exp_q[$];
  logic                  exp_last_q[$];
  pcie_dl_pkg::dword_t   got_q[$];
  logic                  got_last_q[$];
  logic                  ack_nak_log[$];
  pcie_dl_pkg::seq_num_t ack_seq_log[$];
  pcie_dl_pkg::seq_num_t exp_seq;
  pcie_tlp_pkg::hdr_credit_t  m_ph;
  pcie_tlp_pkg::data_credit_t m_pd;
  pcie_tlp_pkg::hdr_credit_t  m_nph;
  pcie_tlp_pkg::data_credit_t m_npd;
  logic [4:0]             cur_type;
  logic                   cur_data;
  pcie_tlp_pkg::tlp_len_t cur_len;

  dl_rx_top u_dl_rx_top (.*);

  always #20 clk_i = ~clk_i;

  // record every completed output beat and ack report
  always @(negedge clk_i) begin
    if (!rst_i && m_axis_tvalid_o && m_axis_tready_i) begin
      got_q.push_back(m_axis_tdata_o);
      got_last_q.push_back(m_axis_tlast_o);
    end
    if (!rst_i && ack_valid_o && ack_ready_i) begin
      ack_nak_log.push_back(ack_nak_o);
      ack_seq_log.push_back(ack_seq_o);
    end
  end

  function automatic pcie_dl_pkg::dword_t rand_dword();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // CRC-32 over the sequence word and the TLP, MSB first, sent complemented
  function automatic pcie_dl_pkg::lcrc_t lcrc_of(pcie_dl_pkg::seq_num_t seq);
    pcie_dl_pkg::dword_t msg[$];
    pcie_dl_pkg::lcrc_t  rem;
    logic                top;
    msg = tlp_q;
    msg.push_front({20'h0, seq});
    rem = pcie_dl_pkg::LCRC_SEED;
    foreach (msg[w]) begin
      for (int b = 31; b >= 0; b--) begin
        top = rem[31];
        rem = rem << 1;
        if (top ^ msg[w][b]) rem = rem ^ pcie_dl_pkg::LCRC_POLY;
      end
    end
    return ~rem;
  endfunction

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic check_dword(input string name, input pcie_dl_pkg::dword_t got,
                             input pcie_dl_pkg::dword_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_seq(input string name, input pcie_dl_pkg::seq_num_t got,
                           input pcie_dl_pkg::seq_num_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_credit(input string name, input pcie_tlp_pkg::data_credit_t got,
                              input pcie_tlp_pkg::data_credit_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // DW0 is fmt, type, length; the other header dwords are random
  task automatic make_tlp(input logic [4:0] kind, input logic data, input logic four_dw,
                          input pcie_tlp_pkg::tlp_len_t len);
    int n_hdr;
    tlp_q.delete();
    n_hdr = four_dw ? 4 : 3;
    tlp_q.push_back({1'b0, data, four_dw, kind, 14'h0, len});
    for (int i = 1; i < n_hdr; i++) tlp_q.push_back(rand_dword());
    if (data) begin
      for (int i = 0; i < len; i++) tlp_q.push_back(rand_dword());
    end
    cur_type = kind;
    cur_data = data;
    cur_len  = len;
  endtask

  // credit rule for a good TLP
  task automatic model_credits();
    pcie_tlp_pkg::data_credit_t dc;
    dc = (cur_len == 0) ? 12'd256 : (cur_len + 12'd3) >> 2;
    if (cur_type != pcie_tlp_pkg::TYPE_CPL) begin
      if (cur_type == pcie_tlp_pkg::TYPE_MEM && cur_data) begin
        m_ph++;
        m_pd = m_pd + dc;
      end else begin
        m_nph++;
        if (cur_data) m_npd = m_npd + dc;
      end
    end
  endtask

  task automatic note_frame(input pcie_dl_pkg::seq_num_t seq, input logic corrupt,
                            output logic good);
    good = !corrupt && (seq == exp_seq);
    if (good) begin
      exp_seq++;
      model_credits();
      foreach (tlp_q[i]) begin
        exp_q.push_back(tlp_q[i]);
        exp_last_q.push_back(i == tlp_q.size() - 1);
      end
    end
  endtask

  task automatic send_frame(input pcie_dl_pkg::seq_num_t seq, input logic corrupt);
    pcie_dl_pkg::dword_t beats[$];
    int                  cnt;
    beats = tlp_q;
    beats.push_front({20'h0, seq});
    beats.push_back(lcrc_of(seq) ^ {31'h0, corrupt});
    foreach (beats[i]) begin
      s_axis_tdata_i  = beats[i];
      s_axis_tlast_i  = (i == beats.size() - 1);
      s_axis_tvalid_i = 1'b1;
      cnt = 0;
      @(negedge clk_i);
      while (!s_axis_tready_o && cnt < 200) begin
        @(negedge clk_i);
        cnt++;
      end
      if (!s_axis_tready_o) begin
        report_error("s_axis_tready_o stayed low while a frame was being sent");
        s_axis_tvalid_i = 1'b0;
        s_axis_tlast_i  = 1'b0;
        return;
      end
      step();
    end
    s_axis_tvalid_i = 1'b0;
    s_axis_tlast_i  = 1'b0;
  endtask

  task automatic wait_acks(input int n);
    int cnt;
    cnt = 0;
    while (ack_nak_log.size() < n && cnt < 200) begin
      step();
      cnt++;
    end
    if (ack_nak_log.size() < n) report_error("no ack/nak report arrived in time");
  endtask

  task automatic check_report(input int idx, input logic good,
                              input pcie_dl_pkg::seq_num_t seq);
    if (ack_nak_log.size() > idx) begin
      check_dword("ack_nak_o", ack_nak_log[idx], !good);
      check_seq("ack_seq_o", ack_seq_log[idx], seq);
    end
  endtask

  task automatic run_frame(input pcie_dl_pkg::seq_num_t seq, input logic corrupt);
    int   idx;
    logic good;
    idx = ack_nak_log.size();
    note_frame(seq, corrupt, good);
    send_frame(seq, corrupt);
    wait_acks(idx + 1);
    check_report(idx, good, exp_seq - 1'b1);
  endtask

  task automatic check_stream();
    int cnt;
    cnt = 0;
    while (got_q.size() < exp_q.size() && cnt < 200) begin
      step();
      cnt++;
    end
    if (got_q.size() != exp_q.size()) begin
      report_error($sformatf("output carried %0d beats instead of %0d",
                             got_q.size(), exp_q.size()));
    end
    foreach (exp_q[i]) begin
      if (i < got_q.size()) begin
        check_dword("m_axis_tdata_o", got_q[i], exp_q[i]);
        check_dword("m_axis_tlast_o", got_last_q[i], exp_last_q[i]);
      end
    end
    exp_q.delete();
    exp_last_q.delete();
    got_q.delete();
    got_last_q.delete();
  endtask

  task automatic expect_no_beats();
    int cnt;
    cnt = 0;
    while (got_q.size() == 0 && cnt < 200) begin
      step();
      cnt++;
    end
    if (got_q.size() != 0) begin
      report_error("a discarded frame reached the output stream");
      got_q.delete();
      got_last_q.delete();
    end
  endtask

  // counters move on the edge after the verdict
  task automatic check_credits();
    step();
    step();
    check_credit("ph_credits_o", ph_credits_o, m_ph);
    check_credit("pd_credits_o", pd_credits_o, m_pd);
    check_credit("nph_credits_o", nph_credits_o, m_nph);
    check_credit("npd_credits_o", npd_credits_o, m_npd);
  endtask

  task automatic finish_test(input string name, input int e0);
    $display("%s: %0d errors", name, errors - e0);
  endtask

  task automatic good_write();
    int e0;
    e0 = errors;
    make_tlp(pcie_tlp_pkg::TYPE_MEM, 1'b1, 1'b1, 10'd8);
    run_frame(exp_seq, 1'b0);
    check_stream();
    check_credits();
    finish_test("good_write", e0);
  endtask

  task automatic bad_lcrc_retry();
    int e0;
    e0 = errors;
    make_tlp(pcie_tlp_pkg::TYPE_MEM, 1'b1, 1'b0, 10'd4);
    run_frame(exp_seq, 1'b1);
    expect_no_beats();
    check_credits();
    run_frame(exp_seq, 1'b0);
    check_stream();
    check_credits();
    finish_test("bad_lcrc_retry", e0);
  endtask

  task automatic wrong_sequence();
    int e0;
    e0 = errors;
    make_tlp(pcie_tlp_pkg::TYPE_MEM, 1'b1, 1'b0, 10'd2);
    run_frame(exp_seq + 12'd3, 1'b0);
    expect_no_beats();
    // the expected number must not have moved
    run_frame(exp_seq, 1'b0);
    check_stream();
    check_credits();
    finish_test("wrong_sequence", e0);
  endtask

  task automatic request_classes();
    int                         e0;
    pcie_tlp_pkg::hdr_credit_t  nph0;
    pcie_tlp_pkg::data_credit_t npd0;
    e0   = errors;
    nph0 = nph_credits_o;
    npd0 = npd_credits_o;
    make_tlp(pcie_tlp_pkg::TYPE_MEM, 1'b0, 1'b1, 10'd4);
    run_frame(exp_seq, 1'b0);
    // configuration write, type 04
    make_tlp(5'h04, 1'b1, 1'b0, 10'd1);
    run_frame(exp_seq, 1'b0);
    make_tlp(pcie_tlp_pkg::TYPE_CPL, 1'b1, 1'b0, 10'd2);
    run_frame(exp_seq, 1'b0);
    check_stream();
    check_credits();
    check_credit("nph_credits_o delta",
                 pcie_tlp_pkg::hdr_credit_t'(nph_credits_o - nph0), 12'd2);
    check_credit("npd_credits_o delta", npd_credits_o - npd0, 12'd1);
    finish_test("request_classes", e0);
  endtask

  task automatic back_pressure();
    int                    e0;
    int                    idx;
    logic                  good_a;
    logic                  good_b;
    pcie_dl_pkg::seq_num_t seq_a;
    pcie_dl_pkg::seq_num_t seq_b;
    e0 = errors;
    m_axis_tready_i = 1'b0;
    for (int k = 0; k < 3; k++) begin
      make_tlp(pcie_tlp_pkg::TYPE_MEM, 1'b1, 1'b1, 10'd4);
      run_frame(exp_seq, 1'b0);
    end
    m_axis_tready_i = 1'b1;
    check_stream();
    // withheld ack_ready_i holds off the next frame
    idx = ack_nak_log.size();
    ack_ready_i = 1'b0;
    seq_a = exp_seq;
    make_tlp(pcie_tlp_pkg::TYPE_MEM, 1'b1, 1'b0, 10'd2);
    note_frame(seq_a, 1'b0, good_a);
    send_frame(seq_a, 1'b0);
    seq_b = exp_seq;
    make_tlp(pcie_tlp_pkg::TYPE_MEM, 1'b1, 1'b0, 10'd3);
    note_frame(seq_b, 1'b0, good_b);
    fork
      send_frame(seq_b, 1'b0);
      begin
        for (int c = 0; c < 20; c++) step();
        if (s_axis_tready_o || !ack_valid_o) begin
          report_error("next frame went through while the ack report was held");
        end
        ack_ready_i = 1'b1;
      end
    join
    wait_acks(idx + 2);
    check_report(idx, good_a, seq_a);
    check_report(idx + 1, good_b, seq_b);
    check_stream();
    check_credits();
    finish_test("back_pressure", e0);
  endtask

  task automatic link_down();
    int   e0;
    int   idx;
    logic seen;
    e0   = errors;
    idx  = ack_nak_log.size();
    seen = 1'b0;
    link_up_i = 1'b0;
    step();
    step();
    // every beat marked last, so leaked beats would close frames
    s_axis_tdata_i  = 32'h0;
    s_axis_tlast_i  = 1'b1;
    s_axis_tvalid_i = 1'b1;
    for (int c = 0; c < 200; c++) begin
      step();
      if (s_axis_tready_o && !seen) begin
        report_error("s_axis_tready_o went high with the link down");
        seen = 1'b1;
      end
    end
    s_axis_tvalid_i = 1'b0;
    s_axis_tlast_i  = 1'b0;
    if (ack_nak_log.size() != idx) report_error("an ack/nak report appeared with the link down");
    link_up_i = 1'b1;
    step();
    finish_test("link_down", e0);
  endtask

  initial begin
    rst_i           = 1'b1;
    link_up_i       = 1'b1;
    s_axis_tdata_i  = '0;
    s_axis_tvalid_i = 1'b0;
    s_axis_tlast_i  = 1'b0;
    m_axis_tready_i = 1'b1;
    ack_ready_i     = 1'b1;
    exp_seq = '0;
    m_ph    = '0;
    m_pd    = '0;
    m_nph   = '0;
    m_npd   = '0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    step();
    good_write();
    bad_lcrc_retry();
    wrong_sequence();
    request_classes();
    back_pressure();
    link_down();
    errors = errors + u_dl_rx_top.u_dl_rx_assert.err_cnt;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tb.f
pcie_dl_pkg.sv
pcie_tlp_pkg.sv
dl_rx_ingress.sv
dl_rx_frame_check.sv
dl_rx_credit_track.sv
dl_rx_frame_buffer.sv
dl_rx_top.sv
dl_rx_assert.sv
tb_dl_rx.sv

// File: Bender.yml
package:
  name: pcie_dl_rx

sources:
  - pcie_dl_pkg.sv
  - pcie_tlp_pkg.sv
  - dl_rx_ingress.sv
  - dl_rx_frame_check.sv
  - dl_rx_credit_track.sv
  - dl_rx_frame_buffer.sv
  - dl_rx_top.sv
  - target: test
    files:
      - dl_rx_assert.sv
      - tb_dl_rx.sv
